// File: mbu.f
+incdir+include
rtl/mbu_pkg.sv
rtl/mbu_uctl_port.sv
rtl/mbu_io_port.sv
rtl/mbu_arbiter.sv
rtl/mbu_bank_regfile.sv
rtl/mbu_top.sv
sim/mbu_checker.sv
sim/mbu_tb.sv

// File: sim/mbu_tb.sv
// Memory bank unit testbench

`default_nettype none

`include "mbu_consts.svh"

module mbu_tb import mbu_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 3000;
   localparam int RESET_CYCLES   = 16;
   localparam logic [15:0] IO_BASE = `MBU_IO_BASE;

   logic        clk;
   logic        arst_n;
   mbu_waddr_e  waddr;
   mbu_raddr_e  raddr;
   logic [2:0]  ir_index;
   logic [7:0]  ibus_in;
   logic [2:0]  window;
   logic        fprom;
   logic [7:0]  ibus_out;
   logic        ibus_valid;
   logic [7:0]  aext;
   logic        write_flags;
   logic        read_flags;
   logic [15:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [15:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   // Reference model of the bank registers
   logic [7:0]  model_mb [`MBU_NUM_BANKS];
   logic        model_en;
   int          seed;
   int          errs;
   int          cycle_cnt;
   mbu_raddr_e  rcode [3];
   mbu_waddr_e  wcode [2];

   mbu_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Run limit, about twice the length of the tests
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("TEST FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Model and checks
   //////////////////////////////////////////////////

   // Disabled registers read the switch default
   function automatic logic [7:0] expected_bank(int idx);
      if (model_en) return model_mb[idx];
      return fprom ? `MBU_ROM_DEFAULT : `MBU_RAM_DEFAULT;
   endfunction

   function automatic void model_write(int idx, logic [7:0] val);
      model_mb[idx] = val;
      model_en      = 1'b1;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         errs++;
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   // Walk every window and compare aext
   task automatic check_windows(input string name);
      for (int w = 0; w < `MBU_NUM_BANKS; w++) begin
         @(posedge clk);
         window <= w[2:0];
         @(negedge clk);
         check_value(name, expected_bank(w), aext);
      end
   endtask

   //////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////

   // Single-cycle AR to MBx code
   task automatic ctl_write(input logic [2:0] idx, input logic [7:0] val);
      @(posedge clk);
      waddr    <= WADDR_AR_MBX;
      ir_index <= idx;
      ibus_in  <= val;
      @(negedge clk);
      check_value("ctl_write_strobe", 0, write_flags);
      @(posedge clk);
      waddr <= WADDR_IDLE;
   endtask

   task automatic ctl_read(input logic [2:0] idx, output logic [7:0] val);
      @(posedge clk);
      raddr    <= RADDR_MBX;
      ir_index <= idx;
      @(posedge clk);
      raddr <= RADDR_IDLE;
      do @(negedge clk); while (!ibus_valid);
      val = ibus_out;
   endtask

   // bready comes one cycle late so the response has to hold
   task automatic axi_write(input logic [15:0] addr, input logic [7:0] val,
                            output logic [1:0] resp);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= {24'h0, val};
      wstrb   <= 4'h1;
      wvalid  <= 1'b1;
      bready  <= 1'b0;
      do @(negedge clk); while (!awready);
      // Data channel is taken together with the address
      check_value("axi_wready", 1, wready);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(negedge clk); while (!bvalid);
      resp = bresp;
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [15:0] addr, output logic [31:0] val,
                           output logic [1:0] resp);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b0;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      val  = rdata;
      resp = rresp;
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      logic [7:0]  rd8;
      logic [7:0]  val;
      logic [7:0]  ctl_val;
      logic [2:0]  idx;
      logic [31:0] rd32;
      logic [1:0]  resp;

      arst_n  = 1'b0;
      waddr   = WADDR_IDLE;
      raddr   = RADDR_IDLE;
      ir_index = '0;
      ibus_in = '0;
      window  = '0;
      fprom   = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      seed     = 51;
      errs     = 0;
      model_en = 1'b0;
      for (int i = 0; i < `MBU_NUM_BANKS; i++) model_mb[i] = '0;
      rcode = '{RADDR_IDLE, RADDR_FLAGS, RADDR_MBX};
      wcode = '{WADDR_IDLE, WADDR_FLAGS};

      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;

      // Power-on defaults follow the ROM switch
      check_windows("poweron_rom");
      @(posedge clk);
      fprom <= 1'b0;
      check_windows("poweron_ram");
      @(posedge clk);
      fprom <= 1'b1;
      ctl_read(3'd3, rd8);
      check_value("poweron_read", expected_bank(3), rd8);

      // Flag strobes over every code pair that writes nothing
      for (int r = 0; r < 3; r++) begin
         for (int w = 0; w < 2; w++) begin
            @(posedge clk);
            raddr <= rcode[r];
            waddr <= wcode[w];
            @(negedge clk);
            check_value("flag_read", rcode[r] == RADDR_FLAGS, read_flags);
            check_value("flag_write", wcode[w] == WADDR_FLAGS, write_flags);
         end
      end
      @(posedge clk);
      raddr <= RADDR_IDLE;
      waddr <= WADDR_IDLE;

      // First control write enables the file
      idx = $random(seed);
      val = $random(seed);
      ctl_write(idx, val);
      model_write(idx, val);
      check_windows("ctl_aext");
      for (int i = 0; i < `MBU_NUM_BANKS; i++) begin
         ctl_read(i[2:0], rd8);
         check_value("ctl_read", expected_bank(i), rd8);
      end

      // AXI writes to the whole window
      for (int i = 0; i < `MBU_NUM_BANKS; i++) begin
         val = $random(seed);
         axi_write(IO_BASE + i[15:0], val, resp);
         check_value("axi_write_resp", `MBU_RESP_OKAY, resp);
         model_write(i, val);
      end
      check_windows("axi_aext");
      for (int i = 0; i < `MBU_NUM_BANKS; i++) begin
         axi_read(IO_BASE + i[15:0], rd32, resp);
         check_value("axi_read_resp", `MBU_RESP_OKAY, resp);
         check_value("axi_read", {24'h0, expected_bank(i)}, rd32);
         ctl_read(i[2:0], rd8);
         check_value("axi_ctl_read", expected_bank(i), rd8);
      end

      // Outside the window, SLVERR and nothing stored
      axi_write(16'h0010, 8'hA5, resp);
      check_value("oow_write_hi", `MBU_RESP_SLVERR, resp);
      axi_write(16'h0000, 8'h5A, resp);
      check_value("oow_write_lo", `MBU_RESP_SLVERR, resp);
      axi_read(16'h0108, rd32, resp);
      check_value("oow_read", `MBU_RESP_SLVERR, resp);
      check_windows("oow_aext");

      // Control write meets the pending I/O write at the arbiter
      // Control port goes first, I/O port lands second
      idx     = $random(seed);
      ctl_val = $random(seed);
      val     = ~ctl_val;
      @(posedge clk);
      window <= idx;
      fork
         axi_write(IO_BASE + {13'h0, idx}, val, resp);
         begin
            do @(negedge clk); while (!awready);
            ctl_write(idx, ctl_val);
            @(negedge clk);
            check_value("arb_ctl_first", ctl_val, aext);
         end
      join
      model_write(idx, val);
      check_value("arb_resp", `MBU_RESP_OKAY, resp);
      check_windows("arb_aext");

      repeat (2) @(posedge clk);
      $display("Checks done with %0d value errors and %0d assertion errors",
               errs, dut_i.chk_i.fail_cnt);
      if (errs == 0 && dut_i.chk_i.fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/mbu_checker.sv
// Memory bank unit protocol checker

`default_nettype none

module mbu_checker import mbu_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  mbu_waddr_e waddr,
   input  mbu_raddr_e raddr,
   input  logic       ibus_valid,
   input  logic       awready,
   input  logic       wready,
   input  logic       arready,
   input  logic [1:0] bresp,
   input  logic       bvalid,
   input  logic       bready,
   input  logic [31:0] rdata,
   input  logic [1:0] rresp,
   input  logic       rvalid,
   input  logic       rready,
   input  mbu_req_t   uctl_req,
   input  mbu_req_t   io_req,
   input  mbu_req_t   rf_req
);

   timeunit 1ns;
   timeprecision 100ps;

   // Failed assertions, read by the testbench at the end
   int fail_cnt = 0;

   //////////////////////////////////////////////////
   // Reset state
   //////////////////////////////////////////////////

   // No handshake, response or request while reset is held
   reset_quiet_a : assert property (@(posedge clk)
      !arst_n |-> !(awready | wready | arready | bvalid | rvalid | ibus_valid |
                    uctl_req.valid | io_req.valid | rf_req.valid))
   else begin
      $error("Handshake or request active during reset");
      fail_cnt++;
   end

   //////////////////////////////////////////////////
   // AXI responses
   //////////////////////////////////////////////////

   // Write response holds until bready
   bvalid_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
   else begin
      $error("bvalid or bresp changed before bready");
      fail_cnt++;
   end

   // Read response holds with its data until rready
   rvalid_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
   else begin
      $error("rvalid, rresp or rdata changed before rready");
      fail_cnt++;
   end

   //////////////////////////////////////////////////
   // Control-unit read timing
   //////////////////////////////////////////////////

   // An MBx read alone gives ibus_valid in the next cycle
   mbx_read_valid_a : assert property (@(posedge clk) disable iff (!arst_n)
      raddr == RADDR_MBX && waddr == WADDR_IDLE |=> ibus_valid)
   else begin
      $error("ibus_valid missing one cycle after an MBx read code");
      fail_cnt++;
   end

   // And ibus_valid never shows up without that code
   ibus_valid_src_a : assert property (@(posedge clk) disable iff (!arst_n)
      ibus_valid |-> $past(raddr) == RADDR_MBX)
   else begin
      $error("ibus_valid without an MBx read code in the cycle before");
      fail_cnt++;
   end

endmodule

// Checker sits inside the top level to see the internal requests
bind mbu_top mbu_checker chk_i (
   .clk, .arst_n, .waddr, .raddr, .ibus_valid,
   .awready, .wready, .arready, .bresp, .bvalid, .bready,
   .rdata, .rresp, .rvalid, .rready,
   .uctl_req, .io_req, .rf_req
);

`default_nettype wire

// File: rtl/mbu_top.sv
// Memory bank unit top level

`default_nettype none

`include "mbu_consts.svh"

module mbu_top import mbu_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   // Control-unit side
   input  mbu_waddr_e             waddr,
   input  mbu_raddr_e             raddr,
   input  logic [2:0]             ir_index,
   input  logic [7:0]             ibus_in,
   input  logic [`MBU_IDX_W-1:0]  window,
   input  logic                   fprom,
   output logic [7:0]             ibus_out,
   output logic                   ibus_valid,
   output logic [7:0]             aext,
   output logic                   write_flags,
   output logic                   read_flags,
   // AXI4-Lite slave
   input  logic [`MBU_AXI_AW-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`MBU_AXI_DW-1:0] wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [`MBU_AXI_AW-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [`MBU_AXI_DW-1:0] rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  logic                   rready
);

   mbu_req_t uctl_req;
   mbu_rsp_t uctl_rsp;
   mbu_req_t io_req;
   mbu_rsp_t io_rsp;
   mbu_req_t rf_req;
   mbu_rsp_t rf_rsp;

   // Processor peer
   mbu_uctl_port uctl_port_i (
      .clk, .arst_n, .waddr, .raddr, .ir_index, .ibus_in,
      .uctl_rsp, .uctl_req, .ibus_out, .ibus_valid, .write_flags, .read_flags
   );

   // I/O space peer
   mbu_io_port io_port_i (
      .clk, .arst_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .io_req, .io_rsp
   );

   // Control port has priority
   mbu_arbiter arbiter_i (
      .clk, .arst_n, .uctl_req, .io_req, .uctl_rsp, .io_rsp, .rf_req, .rf_rsp
   );

   mbu_bank_regfile regfile_i (
      .clk, .arst_n, .rf_req, .rf_rsp, .window, .fprom, .aext
   );

endmodule

`default_nettype wire

// File: rtl/mbu_bank_regfile.sv
// Bank register file

`default_nettype none

`include "mbu_consts.svh"

module mbu_bank_regfile import mbu_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  mbu_req_t              rf_req,
   output mbu_rsp_t              rf_rsp,
   input  logic [`MBU_IDX_W-1:0] window,
   input  logic                  fprom,
   output logic [7:0]            aext
);

   logic [7:0] mb_q [`MBU_NUM_BANKS];
   logic       en_q;
   logic       ack_q;
   logic [7:0] rdata_q;
   logic [7:0] dflt;

   // ROM switch high points every window at ROM
   assign dflt = fprom ? `MBU_ROM_DEFAULT : `MBU_RAM_DEFAULT;

   //////////////////////////////////////////////////
   // Registers and power-on enable
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `MBU_NUM_BANKS; i++) begin
            mb_q[i] <= '0;
         end
         en_q <= 1'b0;
      end else if (rf_req.valid && rf_req.we) begin
         mb_q[rf_req.index] <= rf_req.wdata;
         // First write switches from defaults to real contents
         en_q <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Shared access port
   //////////////////////////////////////////////////

   // Every request is acked one cycle later
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= rf_req.valid;
      end
   end

   // Read data, old contents on a write
   always_ff @(posedge clk) begin
      if (rf_req.valid) begin
         rdata_q <= en_q ? mb_q[rf_req.index] : dflt;
      end
   end

   assign rf_rsp.ack   = ack_q;
   assign rf_rsp.rdata = rdata_q;

   // Address extension, straight from the window number
   assign aext = en_q ? mb_q[window] : dflt;

endmodule

`default_nettype wire

// File: rtl/mbu_arbiter.sv
// Bank register arbiter

`default_nettype none

module mbu_arbiter import mbu_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  mbu_req_t uctl_req,
   input  mbu_req_t io_req,
   output mbu_rsp_t uctl_rsp,
   output mbu_rsp_t io_rsp,
   output mbu_req_t rf_req,
   input  mbu_rsp_t rf_rsp
);

   mbu_arb_state_e grant_q;
   mbu_arb_state_e grant_d;
   logic           io_elig;

   // I/O request is still valid in its ack cycle, skip it then
   assign io_elig = io_req.valid & (grant_q != GRANT_IO);

   //////////////////////////////////////////////////
   // Grant, control port first
   //////////////////////////////////////////////////

   always_comb begin
      rf_req  = '0;
      grant_d = GRANT_NONE;
      if (uctl_req.valid) begin
         rf_req  = uctl_req;
         grant_d = GRANT_UCTL;
      end else if (io_elig) begin
         rf_req  = io_req;
         grant_d = GRANT_IO;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         grant_q <= GRANT_NONE;
      end else begin
         grant_q <= grant_d;
      end
   end

   //////////////////////////////////////////////////
   // Response steering
   //////////////////////////////////////////////////

   // Both peers see rdata, only the granted one sees ack
   assign uctl_rsp.ack   = rf_rsp.ack & (grant_q == GRANT_UCTL);
   assign uctl_rsp.rdata = rf_rsp.rdata;
   assign io_rsp.ack     = rf_rsp.ack & (grant_q == GRANT_IO);
   assign io_rsp.rdata   = rf_rsp.rdata;

endmodule

`default_nettype wire

// File: rtl/mbu_io_port.sv
// AXI4-Lite I/O port

`default_nettype none

`include "mbu_consts.svh"

module mbu_io_port import mbu_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [`MBU_AXI_AW-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`MBU_AXI_DW-1:0] wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [`MBU_AXI_AW-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [`MBU_AXI_DW-1:0] rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  logic                   rready,
   output mbu_req_t               io_req,
   input  mbu_rsp_t               io_rsp
);

   localparam int unsigned WIN_LSB = `MBU_IDX_W;
   localparam logic [`MBU_AXI_AW-1:0] IO_BASE = `MBU_IO_BASE;

   logic                  idle;
   logic                  wr_go;
   logic                  rd_go;
   logic                  aw_in_win;
   logic                  ar_in_win;
   logic                  busy_q;
   logic                  bvalid_q;
   logic                  rvalid_q;
   logic [1:0]            bresp_q;
   logic [1:0]            rresp_q;
   // Request payload and read data
   logic                  we_q;
   logic [`MBU_IDX_W-1:0] idx_q;
   logic [7:0]            wdat_q;
   logic [7:0]            rdat_q;

   // Window match on the address bits above the register index
   assign aw_in_win = (awaddr[`MBU_AXI_AW-1:WIN_LSB] == IO_BASE[`MBU_AXI_AW-1:WIN_LSB]);
   assign ar_in_win = (araddr[`MBU_AXI_AW-1:WIN_LSB] == IO_BASE[`MBU_AXI_AW-1:WIN_LSB]);

   //////////////////////////////////////////////////
   // Address acceptance
   //////////////////////////////////////////////////

   // Nothing outstanding and no response waiting
   assign idle  = ~busy_q & ~bvalid_q & ~rvalid_q;
   // Write needs address and data together, and goes before a read
   assign wr_go = idle & awvalid & wvalid;
   assign rd_go = idle & arvalid & ~(awvalid & wvalid);

   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = rd_go;

   //////////////////////////////////////////////////
   // Transaction control
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q   <= 1'b0;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
         bresp_q  <= `MBU_RESP_OKAY;
         rresp_q  <= `MBU_RESP_OKAY;
      end else begin
         if (wr_go) begin
            // Out of window gets SLVERR at once
            // A write without byte 0 strobe has nothing to store
            if (!aw_in_win) begin
               bvalid_q <= 1'b1;
               bresp_q  <= `MBU_RESP_SLVERR;
            end else if (!wstrb[0]) begin
               bvalid_q <= 1'b1;
               bresp_q  <= `MBU_RESP_OKAY;
            end else begin
               busy_q <= 1'b1;
            end
         end else if (rd_go) begin
            if (!ar_in_win) begin
               rvalid_q <= 1'b1;
               rresp_q  <= `MBU_RESP_SLVERR;
            end else begin
               busy_q <= 1'b1;
            end
         end
         // Ack ends the register access, response follows next cycle
         if (busy_q && io_rsp.ack) begin
            busy_q <= 1'b0;
            if (we_q) begin
               bvalid_q <= 1'b1;
               bresp_q  <= `MBU_RESP_OKAY;
            end else begin
               rvalid_q <= 1'b1;
               rresp_q  <= `MBU_RESP_OKAY;
            end
         end
         // Responses hold until the master takes them
         if (bvalid_q && bready) bvalid_q <= 1'b0;
         if (rvalid_q && rready) rvalid_q <= 1'b0;
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (wr_go) begin
         we_q   <= 1'b1;
         idx_q  <= awaddr[`MBU_IDX_W-1:0];
         wdat_q <= wdata[7:0];
      end else if (rd_go) begin
         we_q   <= 1'b0;
         idx_q  <= araddr[`MBU_IDX_W-1:0];
         wdat_q <= '0;
      end
      // SLVERR reads return zero
      if (rd_go && !ar_in_win) rdat_q <= '0;
      if (busy_q && io_rsp.ack && !we_q) rdat_q <= io_rsp.rdata;
   end

   assign io_req.valid = busy_q;
   assign io_req.we    = we_q;
   assign io_req.index = idx_q;
   assign io_req.wdata = wdat_q;

   assign bvalid = bvalid_q;
   assign bresp  = bresp_q;
   assign rvalid = rvalid_q;
   assign rresp  = rresp_q;
   assign rdata  = {{(`MBU_AXI_DW-8){1'b0}}, rdat_q};

endmodule

`default_nettype wire

// File: rtl/mbu_uctl_port.sv
// Control-unit port

`default_nettype none

module mbu_uctl_port import mbu_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  mbu_waddr_e waddr,
   input  mbu_raddr_e raddr,
   input  logic [2:0] ir_index,
   input  logic [7:0] ibus_in,
   input  mbu_rsp_t   uctl_rsp,
   output mbu_req_t   uctl_req,
   output logic [7:0] ibus_out,
   output logic       ibus_valid,
   output logic       write_flags,
   output logic       read_flags
);

   // Code values as plain vectors for the decoder selects
   localparam logic [4:0] RD_FLG = RADDR_FLAGS;
   localparam logic [4:0] RD_MBX = RADDR_MBX;
   localparam logic [4:0] WR_FLG = WADDR_FLAGS;
   localparam logic [4:0] WR_MBX = WADDR_AR_MBX;

   logic [7:0] rdec;
   logic [7:0] wdec;
   logic       rd_mbx;
   logic       wr_mbx;
   logic       rd_pend_q;

   //////////////////////////////////////////////////
   // Code decoders
   //////////////////////////////////////////////////

   // 3-to-8 decoders, enabled on the 01xxx group
   always_comb begin
      rdec = '0;
      wdec = '0;
      if (raddr[4:3] == RD_FLG[4:3]) rdec[raddr[2:0]] = 1'b1;
      if (waddr[4:3] == WR_FLG[4:3]) wdec[waddr[2:0]] = 1'b1;
   end

   // Flag unit strobes, same cycle as the code
   assign read_flags  = rdec[RD_FLG[2:0]];
   assign write_flags = wdec[WR_FLG[2:0]];

   // MBx read shares the read decoder
   assign rd_mbx = rdec[RD_MBX[2:0]];
   // AR to MBx covers the whole 001xx group
   assign wr_mbx = (waddr[4:2] == WR_MBX[4:2]);

   //////////////////////////////////////////////////
   // Bank register request
   //////////////////////////////////////////////////

   // Single-cycle request, write wins over a read in the same cycle
   assign uctl_req.valid = wr_mbx | rd_mbx;
   assign uctl_req.we    = wr_mbx;
   assign uctl_req.index = ir_index;
   assign uctl_req.wdata = ibus_in;

   // Remember an issued read until its ack comes back
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= rd_mbx & ~wr_mbx;
      end
   end

   // Register file rdata is already registered
   assign ibus_out   = uctl_rsp.rdata;
   assign ibus_valid = rd_pend_q & uctl_rsp.ack;

endmodule

`default_nettype wire

// File: rtl/mbu_pkg.sv
// Memory bank unit types

`default_nettype none

`include "mbu_consts.svh"

package mbu_pkg;

   // Control-unit read codes
   // Flags and MBx share the 01xxx decoder group
   typedef enum logic [4:0] {
      RADDR_IDLE  = 5'b00000,
      RADDR_FLAGS = 5'b01101,
      RADDR_MBX   = 5'b01110
   } mbu_raddr_e;

   // Control-unit write codes
   // AR to MBx lives in the 001xx group, flags in 01xxx
   typedef enum logic [4:0] {
      WADDR_IDLE   = 5'b00000,
      WADDR_AR_MBX = 5'b00100,
      WADDR_FLAGS  = 5'b01101
   } mbu_waddr_e;

   // Last grant given by the arbiter
   typedef enum logic [1:0] {
      GRANT_NONE = 2'b00,
      GRANT_UCTL = 2'b01,
      GRANT_IO   = 2'b10
   } mbu_arb_state_e;

   // Bank register request from a peer
   typedef struct packed {
      logic                  valid;
      logic                  we;
      logic [`MBU_IDX_W-1:0] index;
      logic [7:0]            wdata;
   } mbu_req_t;

   // Response, one cycle after the grant
   typedef struct packed {
      logic       ack;
      logic [7:0] rdata;
   } mbu_rsp_t;

endpackage

`default_nettype wire

// File: include/mbu_consts.svh
// Memory bank unit constants

`ifndef MBU_CONSTS_SVH
`define MBU_CONSTS_SVH

// Bank register file size and index width
`define MBU_NUM_BANKS     8
`define MBU_IDX_W         $clog2(`MBU_NUM_BANKS)

// I/O window, MB0 at 0x008 up to MB7 at 0x00F
`define MBU_IO_BASE       16'h0008

// Values read while the bank registers are still disabled
`define MBU_ROM_DEFAULT   8'h80
`define MBU_RAM_DEFAULT   8'h00

// AXI4-Lite bus widths and response codes
`define MBU_AXI_AW        16
`define MBU_AXI_DW        32
`define MBU_RESP_OKAY     2'b00
`define MBU_RESP_SLVERR   2'b10

`endif
